/* design/icache_cfg_pkg.sv */
`default_nettype none

package icache_cfg_pkg;

    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int NUM_WAYS       = 2;
    localparam int NUM_SETS       = 16;
    localparam int INDEX_W        = 4;
    localparam int WORDS_PER_LINE = 4;
    localparam int WOFF_W         = 2;
    localparam int TAG_W          = 24;
    localparam int LINE_W         = 128;   // WORDS_PER_LINE * WORD_W

    typedef logic [TAG_W-1:0]            tag_t;
    typedef logic [INDEX_W-1:0]          index_t;
    typedef logic [WOFF_W-1:0]           woff_t;
    typedef logic [LINE_W-1:0]           line_t;
    typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

    // field view of a fetch address, msb first
    typedef struct packed {
        tag_t       tag;
        index_t     index;
        woff_t      woff;
        logic [1:0] boff;
    } addr_fields_t;

    // same 32 bits, seen either flat or split into cache fields
    typedef union packed {
        logic [ADDR_W-1:0] word;
        addr_fields_t      f;
    } fetch_addr_t;

endpackage

`default_nettype wire

/* design/icache_if_pkg.sv */
`default_nettype none

package icache_if_pkg;

    import icache_cfg_pkg::*;

    // core to cache, two word addresses per fetch
    typedef struct packed {
        fetch_addr_t addr_1;
        fetch_addr_t addr_2;
    } fetch_req_t;

    // cache to core
    typedef struct packed {
        logic [WORD_W-1:0] rdata_1;
        logic [WORD_W-1:0] rdata_2;
        logic              second_ok;   // rdata_2 holds data
    } fetch_rsp_t;

    // memory address channel, byte address of one aligned word
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } mem_req_t;

    // memory data channel
    typedef struct packed {
        logic [WORD_W-1:0] data;
    } mem_rsp_t;

endpackage

`default_nettype wire

/* design/icache_way_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module icache_way_ram
    import icache_cfg_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  index_t index,
    input  logic   wr_en,
    input  index_t wr_index,
    input  tag_t   wr_tag,
    input  line_t  wr_line,
    output tag_t   rd_tag,
    output logic   rd_valid,
    output line_t  rd_line
);

    tag_t                tag_mem  [NUM_SETS];
    line_t               line_mem [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;

    // lookup reads are combinational
    assign rd_tag   = tag_mem[index];
    assign rd_line  = line_mem[index];
    assign rd_valid = valid_q[index];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    // tag and data storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index]  <= wr_tag;
            line_mem[wr_index] <= wr_line;
        end
    end

    // an unknown write would leave the valid bit of its set unknown
    a_wr_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        !$isunknown(wr_en) && (!wr_en || !$isunknown(wr_index))
    );

endmodule

`default_nettype wire

/* design/icache_replace.sv */
`timescale 1ns/1ns
`default_nettype none

module icache_replace
    import icache_cfg_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  index_t index,
    input  logic   refill_done,
    output way_t   victim
);

    way_t ptr_q [NUM_SETS];   // round robin pointer per set

    assign victim = ptr_q[index];

    // advance to the other way once the current victim has been filled
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                ptr_q[s] <= '0;
            end
        end else if (refill_done) begin
            ptr_q[index] <= ptr_q[index] + way_t'(1);
        end
    end

endmodule

`default_nettype wire

/* design/icache_refill.sv */
`timescale 1ns/1ns
`default_nettype none

module icache_refill
    import icache_cfg_pkg::*;
    import icache_if_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        miss,
    input  fetch_addr_t miss_addr,
    input  logic        mem_req_ready,
    input  mem_rsp_t    mem_rsp,
    input  logic        mem_rsp_valid,
    output mem_req_t    mem_req,
    output logic        mem_req_valid,
    output logic        refill_done,
    output line_t       refill_line
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT,
        S_DONE
    } state_t;

    state_t      state_q;
    woff_t       cnt_q;       // word being fetched
    fetch_addr_t base_q;      // address of the missing line
    fetch_addr_t word_addr;
    line_t       line_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (miss) begin
                        state_q <= S_REQ;
                        cnt_q   <= '0;
                    end
                end
                S_REQ: begin
                    if (mem_req_ready) state_q <= S_WAIT;
                end
                S_WAIT: begin
                    if (mem_rsp_valid) begin
                        if (cnt_q == woff_t'(WORDS_PER_LINE - 1)) begin
                            state_q <= S_DONE;
                        end else begin
                            state_q <= S_REQ;   // next word only after data is back
                            cnt_q   <= cnt_q + woff_t'(1);
                        end
                    end
                end
                default: state_q <= S_IDLE;    // S_DONE lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && miss) begin
            base_q <= miss_addr;
        end
        if (state_q == S_WAIT && mem_rsp_valid) begin
            line_q[cnt_q*WORD_W +: WORD_W] <= mem_rsp.data;
        end
    end

    // line address with the word counter in the offset field
    always_comb begin
        word_addr        = base_q;
        word_addr.f.woff = cnt_q;
        word_addr.f.boff = '0;
    end

    assign mem_req.addr  = word_addr.word;
    assign mem_req_valid = (state_q == S_REQ);
    assign refill_done   = (state_q == S_DONE);
    assign refill_line   = line_q;

    a_req_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req)
    );

    // memory only answers requests we issued
    a_no_rsp_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        (state_q == S_IDLE) |-> !mem_rsp_valid
    );

endmodule

`default_nettype wire

/* design/icache_top.sv */
`timescale 1ns/1ns
`default_nettype none

module icache_top
    import icache_cfg_pkg::*;
    import icache_if_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  fetch_req_t req,
    input  logic       req_valid,
    output logic       req_ready,
    output fetch_rsp_t rsp,
    output logic       rsp_valid,
    input  logic       rsp_ready,
    output mem_req_t   mem_req,
    output logic       mem_req_valid,
    input  logic       mem_req_ready,
    input  mem_rsp_t   mem_rsp,
    input  logic       mem_rsp_valid
);

    tag_t                way_tag   [NUM_WAYS];
    logic                way_valid [NUM_WAYS];
    line_t               way_line  [NUM_WAYS];
    logic [NUM_WAYS-1:0] hit_vec;
    logic                hit;
    way_t                hit_way;
    line_t               hit_line;
    way_t                victim;
    logic                miss;
    logic                refill_busy_q;
    logic                refill_done;
    line_t               refill_line;
    fetch_rsp_t          rsp_d;
    fetch_rsp_t          rsp_q;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        icache_way_ram u_way_ram (
            .clk      (clk),
            .arst_n   (arst_n),
            .index    (req.addr_1.f.index),
            .wr_en    (refill_done && (victim == way_t'(w))),
            .wr_index (req.addr_1.f.index),
            .wr_tag   (req.addr_1.f.tag),
            .wr_line  (refill_line),
            .rd_tag   (way_tag[w]),
            .rd_valid (way_valid[w]),
            .rd_line  (way_line[w])
        );

        assign hit_vec[w] = way_valid[w] && (way_tag[w] == req.addr_1.f.tag);
    end

    icache_replace u_replace (
        .clk         (clk),
        .arst_n      (arst_n),
        .index       (req.addr_1.f.index),
        .refill_done (refill_done),
        .victim      (victim)
    );

    icache_refill u_refill (
        .clk           (clk),
        .arst_n        (arst_n),
        .miss          (miss),
        .miss_addr     (req.addr_1),
        .mem_req_ready (mem_req_ready),
        .mem_rsp       (mem_rsp),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .refill_done   (refill_done),
        .refill_line   (refill_line)
    );

    assign hit = |hit_vec;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_vec[w]) hit_way = way_t'(w);
        end
    end

    assign hit_line = way_line[hit_way];

    // second word only comes from the same line
    always_comb begin
        rsp_d.rdata_1   = hit_line[req.addr_1.f.woff*WORD_W +: WORD_W];
        rsp_d.second_ok = (req.addr_1.f.tag == req.addr_2.f.tag) &&
                          (req.addr_1.f.index == req.addr_2.f.index);
        rsp_d.rdata_2   = rsp_d.second_ok ? hit_line[req.addr_2.f.woff*WORD_W +: WORD_W] : '0;
    end

    assign req_ready = req_valid && hit && (!rsp_valid || rsp_ready);
    assign miss      = req_valid && !hit && !refill_busy_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            refill_busy_q <= 1'b0;
            rsp_valid     <= 1'b0;
        end else begin
            if (miss) refill_busy_q <= 1'b1;
            else if (refill_done) refill_busy_q <= 1'b0;

            if (req_ready) rsp_valid <= 1'b1;
            else if (rsp_ready) rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_ready) rsp_q <= rsp_d;   // held while the core stalls
    end

    assign rsp = rsp_q;

    // refills only fill a set on a miss, so a tag never sits in two ways
    a_single_hit: assert property (
        @(posedge clk) disable iff (!arst_n)
        req_valid |-> $onehot0(hit_vec)
    );

endmodule

`default_nettype wire

/* verif/tb_clkgen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

endmodule

`default_nettype wire

/* verif/icache_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module icache_tb
    import icache_cfg_pkg::*;
    import icache_if_pkg::*;
;

    localparam int NUM_ROWS = 12;
    localparam int TIMEOUT  = 200;

    typedef struct packed {
        fetch_addr_t addr_1;
        fetch_addr_t addr_2;
        logic        second_ok;
        int          reads;       // memory reads the row should cost
        int          stall;       // cycles rsp_ready is held low
    } row_t;

    logic       clk;
    logic       arst_n;
    fetch_req_t req;
    logic       req_valid;
    logic       req_ready;
    fetch_rsp_t rsp;
    logic       rsp_valid;
    logic       rsp_ready;
    mem_req_t   mem_req;
    logic       mem_req_valid;
    logic       mem_req_ready;
    mem_rsp_t   mem_rsp;
    logic       mem_rsp_valid;
    row_t       rows [NUM_ROWS];
    int         mem_reads;
    int         err_cnt;
    int         timeout_cnt;

    tb_clkgen u_clkgen (.clk(clk));

    icache_top u_dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .req           (req),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .rsp           (rsp),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_rsp       (mem_rsp),
        .mem_rsp_valid (mem_rsp_valid)
    );

    function automatic fetch_addr_t line_addr(input tag_t tag, input index_t idx, input woff_t woff);
        fetch_addr_t a;
        a.f.tag   = tag;
        a.f.index = idx;
        a.f.woff  = woff;
        a.f.boff  = 2'b00;
        return a;
    endfunction

    // memory content rule
    function automatic logic [WORD_W-1:0] mem_word(input logic [ADDR_W-1:0] a);
        return {a[ADDR_W-1:2], 2'b00} ^ 32'hA5A5_0000;
    endfunction

    task automatic check_rsp(input fetch_rsp_t got, input fetch_rsp_t exp, input string name);
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string name);
        if (got != exp) begin
            err_cnt++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic wait_accept(input int r, output bit ok);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!req_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        ok = req_ready;
        if (!ok) begin
            timeout_cnt++;
            $display("row %0d: the cache never accepted the request", r);
        end
    endtask

    task automatic wait_response(input int r, output bit ok);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!rsp_valid && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        ok = rsp_valid;
        if (!ok) begin
            timeout_cnt++;
            $display("row %0d: no response came back from the cache", r);
        end
    endtask

    task automatic run_row(input int r);
        row_t       row;
        fetch_rsp_t exp;
        fetch_rsp_t held;
        int         reads_before;
        bit         ok;
        row           = rows[r];
        exp.rdata_1   = mem_word(row.addr_1.word);
        exp.second_ok = row.second_ok;
        exp.rdata_2   = row.second_ok ? mem_word(row.addr_2.word) : '0;
        reads_before  = mem_reads;
        @(posedge clk);
        #2;
        req.addr_1 = row.addr_1;
        req.addr_2 = row.addr_2;
        req_valid  = 1'b1;
        wait_accept(r, ok);
        if (ok) begin
            @(posedge clk);   // request transfers here
            #2;
            req_valid = (row.stall > 0);   // keep asking while stalled
            wait_response(r, ok);
        end
        if (ok) begin
            check_rsp(rsp, exp, "rsp");
            held = rsp;
            repeat (row.stall) begin
                @(negedge clk);
                check_rsp(rsp, held, "rsp");
                check_flag(req_ready, 1'b0, "req_ready");
                check_flag(rsp_valid, 1'b1, "rsp_valid");
            end
            @(posedge clk);
            #2;
            req_valid = 1'b0;
            rsp_ready = 1'b1;
            @(posedge clk);
            #2;
            rsp_ready = 1'b0;
            @(negedge clk);
            check_flag(rsp_valid, 1'b0, "rsp_valid");
            check_count(mem_reads - reads_before, row.reads, "mem_reads");
        end
    endtask

    // memory model, one word per request, answers in order
    initial begin
        int               delay;
        logic [ADDR_W-1:0] addr;
        void'($urandom(32'h4573));
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        mem_reads     = 0;
        forever begin
            @(negedge clk);
            if (arst_n && mem_req_valid) begin
                addr  = mem_req.addr;
                delay = $urandom % 4;
                repeat (delay) @(posedge clk);
                @(posedge clk);
                #2 mem_req_ready = 1'b1;
                @(posedge clk);
                #2 mem_req_ready = 1'b0;
                mem_reads++;
                delay = $urandom % 3 + 1;
                repeat (delay) @(posedge clk);
                #2;
                mem_rsp.data  = mem_word(addr);
                mem_rsp_valid = 1'b1;
                @(posedge clk);
                #2 mem_rsp_valid = 1'b0;
            end
        end
    end

    initial begin
        err_cnt     = 0;
        timeout_cnt = 0;
        arst_n      = 1'b0;
        req         = '0;
        req_valid   = 1'b1;   // held in reset, nothing may hit yet
        rsp_ready   = 1'b0;

        // addr_1, addr_2, second_ok, reads, stall
        rows[0]  = '{line_addr(24'h000010, 4'd1, 2'd0), line_addr(24'h000010, 4'd1, 2'd3), 1'b1, 4, 0};
        rows[1]  = '{line_addr(24'h000010, 4'd1, 2'd2), line_addr(24'h000010, 4'd1, 2'd1), 1'b1, 0, 3};
        rows[2]  = '{line_addr(24'h000010, 4'd1, 2'd3), line_addr(24'h000020, 4'd1, 2'd0), 1'b0, 0, 0};
        rows[3]  = '{line_addr(24'h000010, 4'd1, 2'd1), line_addr(24'h000010, 4'd2, 2'd1), 1'b0, 0, 0};
        rows[4]  = '{line_addr(24'h000100, 4'd3, 2'd0), line_addr(24'h000100, 4'd3, 2'd2), 1'b1, 4, 0};
        rows[5]  = '{line_addr(24'h000200, 4'd3, 2'd1), line_addr(24'h000200, 4'd3, 2'd1), 1'b1, 4, 0};
        rows[6]  = '{line_addr(24'h000300, 4'd3, 2'd2), line_addr(24'h000300, 4'd3, 2'd0), 1'b1, 4, 1};
        rows[7]  = '{line_addr(24'h000200, 4'd3, 2'd3), line_addr(24'h000200, 4'd3, 2'd0), 1'b1, 0, 0};
        rows[8]  = '{line_addr(24'h000100, 4'd3, 2'd1), line_addr(24'h000100, 4'd3, 2'd3), 1'b1, 4, 0};
        rows[9]  = '{line_addr(24'h000200, 4'd3, 2'd0), line_addr(24'h000300, 4'd3, 2'd0), 1'b0, 4, 0};
        rows[10] = '{line_addr(24'h000100, 4'd3, 2'd2), line_addr(24'h000100, 4'd3, 2'd1), 1'b1, 0, 2};
        rows[11] = '{line_addr(24'h000300, 4'd3, 2'd3), line_addr(24'h000300, 4'd3, 2'd3), 1'b1, 4, 0};

        repeat (2) @(posedge clk);
        @(negedge clk);
        check_flag(req_ready, 1'b0, "req_ready");
        @(posedge clk);
        #2;
        arst_n    = 1'b1;
        req_valid = 1'b0;
        @(negedge clk);
        check_flag(rsp_valid, 1'b0, "rsp_valid");
        check_flag(mem_req_valid, 1'b0, "mem_req_valid");

        for (int r = 0; r < NUM_ROWS; r++) begin
            if (timeout_cnt == 0) run_row(r);
        end

        $display("errors: %0d value mismatches, %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* icache_top.f */
design/icache_cfg_pkg.sv
design/icache_if_pkg.sv
design/icache_way_ram.sv
design/icache_replace.sv
design/icache_refill.sv
design/icache_top.sv
verif/tb_clkgen.sv
verif/icache_tb.sv

/* Makefile */
SIM   = verilator
FLAGS = --binary --timing --assert
TOP   = icache_tb
FLIST = icache_top.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
